/* dv/prog.hex */
// One 32-bit instruction word per line, first line at boot_addr
// Registers: t0=$8 t1=$9 t2=$10 t3=$11 s0=ram_base s1=gpio_addr
20080005 // addi t0, zero, 5
20090007 // addi t1, zero, 7
34101001 // ori  s0, zero, 0x1001
00108400 // sll  s0, s0, 16
36110100 // ori  s1, s0, 0x0100
01095020 // add  t2, t0, t1
AE2A0000 // sw   t2, 0(s1)
01285022 // sub  t2, t1, t0
AE2A0000 // sw   t2, 0(s1)
000850C0 // sll  t2, t0, 3
AE2A0000 // sw   t2, 0(s1)
0109502A // slt  t2, t0, t1
AE2A0000 // sw   t2, 0(s1)
340B00A5 // ori  t3, zero, 0xA5
AE0B0000 // sw   t3, 0(s0)
8E0A0000 // lw   t2, 0(s0)
AE2A0000 // sw   t2, 0(s1)
11080002 // beq  t0, t0, +2
340A00EE // ori  t2, zero, 0xEE
AE2A0000 // sw   t2, 0(s1)
15080002 // bne  t0, t0, +2
340A003C // ori  t2, zero, 0x3C
AE2A0000 // sw   t2, 0(s1)
0C10001B // jal  subroutine
340A0099 // ori  t2, zero, 0x99
AE2A0000 // sw   t2, 0(s1)
0810001A // j    to itself
340A0077 // subroutine: ori t2, zero, 0x77
AE2A0000 // sw   t2, 0(s1)
03E00008 // jr   ra

/* all.f */
common/mips_pkg.sv
core/pc_unit.sv
core/instr_decoder.sv
core/reg_file.sv
core/alu.sv
mem/instr_rom.sv
mem/data_bus.sv
hdl/mips_top.sv
dv/mips_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MIPS testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module mips_tb \
    --Mdir obj_dir -o mips_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mips_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

/* dv/mips_tb.sv */
module mips_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half       = 50;   // 100 ns period
    localparam int reset_cycles   = 8;
    localparam int change_timeout = 50;   // Cycles allowed between two GPIO stores
    localparam int hold_cycles    = 20;

    // GPIO bytes in the order the program stores them
    localparam logic [7:0] exp_list [8] = '{
        8'h0C, 8'h02, 8'h28, 8'h01, 8'hA5, 8'h3C, 8'h77, 8'h99
    };

    logic       clk;
    logic       rst_n;
    logic [7:0] gpio_data_out;

    logic [7:0] gpio_prev;                // GPIO value of the previous cycle
    logic [3:0] chg_idx;                  // Number of GPIO changes seen so far
    logic       stalled;
    int         error_count;
    int         pass_count;
    int         fail_count;

    mips_top mips_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .gpio_data_out(gpio_data_out)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // Change tracker, same edge and same samples as the assertions below
    always @(posedge clk) begin
        if (!rst_n) begin
            chg_idx <= 4'd0;
        end else if (gpio_data_out != gpio_prev) begin
            chg_idx <= chg_idx + 4'd1;
        end
        gpio_prev <= gpio_data_out;
    end

    // Every change must be the next byte of the list
    assert property (@(posedge clk) disable iff (!rst_n)
        ((gpio_data_out != gpio_prev) && (chg_idx < 4'd8))
            |-> (gpio_data_out == exp_list[chg_idx[2:0]]))
        else begin
            $display("[ERROR] %0t gpio_data_out expected %02h actual %02h", $time,
                     $sampled(exp_list[chg_idx[2:0]]), $sampled(gpio_data_out));
            error_count++;
        end

    // Nothing may change once the list is used up
    assert property (@(posedge clk) disable iff (!rst_n)
        (gpio_data_out != gpio_prev) |-> (chg_idx < 4'd8))
        else begin
            $display("GPIO changed to %02h after the last expected value at %0t",
                     $sampled(gpio_data_out), $time);
            error_count++;
        end

    task automatic expect_gpio(input logic [7:0] expected);
        assert (gpio_data_out == expected)
            else begin
                $display("[ERROR] %0t gpio_data_out expected %02h actual %02h", $time,
                         expected, gpio_data_out);
                error_count++;
            end
    endtask

    // Sample on falling edges until the count of changes reaches count
    task automatic wait_for_change(input logic [3:0] count);
        int cycles;
        cycles = 0;
        while (!stalled && (chg_idx < count) && (cycles < change_timeout)) begin
            @(negedge clk);
            cycles++;
        end
        if (!stalled && (chg_idx < count)) begin
            $display("Program stalled, GPIO change %0d not seen within %0d cycles",
                     count, change_timeout);
            error_count++;
            stalled = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("Test %s: ok", name);
        end else begin
            fail_count++;
            $display("Test %s: FAIL", name);
        end
    endtask

    task automatic reset_clears_gpio();
        int errs_before;
        errs_before = error_count;
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            expect_gpio(8'h00);           // Cleared by the synchronous reset
        end
        rst_n = 1'b1;                     // Released on a falling edge
        @(negedge clk);
        expect_gpio(8'h00);               // First instruction is no store
        report_test("1 reset", errs_before);
    endtask

    task automatic arithmetic_stores();
        int errs_before;
        errs_before = error_count;
        wait_for_change(4'd1);            // add result
        wait_for_change(4'd2);            // sub result
        report_test("2 arithmetic", errs_before);
    endtask

    task automatic shift_and_compare();
        int errs_before;
        errs_before = error_count;
        wait_for_change(4'd3);
        wait_for_change(4'd4);
        report_test("3 shift and compare", errs_before);
    endtask

    task automatic memory_round_trip();
        int errs_before;
        errs_before = error_count;
        wait_for_change(4'd5);            // Byte came back through lw
        report_test("4 memory", errs_before);
    endtask

    task automatic branch_selection();
        int errs_before;
        errs_before = error_count;
        wait_for_change(4'd6);            // A skipped store would show up here first
        report_test("5 branches", errs_before);
    endtask

    task automatic call_and_return();
        int errs_before;
        errs_before = error_count;
        wait_for_change(4'd7);
        wait_for_change(4'd8);
        if (!stalled) begin
            repeat (hold_cycles) @(negedge clk);  // Core spins on j to itself
            expect_gpio(8'h99);
            assert (chg_idx == 4'd8)
                else begin
                    $display("GPIO kept changing while the program should idle");
                    error_count++;
                end
        end
        report_test("6 calls", errs_before);
    endtask

    initial begin
        rst_n       = 1'b0;
        stalled     = 1'b0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;

        reset_clears_gpio();
        if (!stalled) arithmetic_stores();
        if (!stalled) shift_and_compare();
        if (!stalled) memory_round_trip();
        if (!stalled) branch_selection();
        if (!stalled) call_and_return();

        $display("Tests: %0d ok, %0d failing", pass_count, fail_count);
        if ((fail_count == 0) && (error_count == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* hdl/mips_top.sv */
module mips_top import mips_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic [7:0] gpio_data_out
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] rom_data;
    instr_t          instr;          // Fetched word, decoded through the union views

    // Control from the decoder
    logic [3:0] alu_op;
    logic       alu_src_imm;
    logic       imm_zero_ext;
    logic [1:0] reg_dst;
    logic       reg_write;
    logic [1:0] wb_sel;
    logic       mem_read;
    logic       mem_write;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    logic       jump_reg;

    // Datapath
    logic [4:0]      wa;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic            zero;
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] wd;

    assign instr = rom_data;

    pc_unit pc_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .rs_data  (rd1),             // jr target
        .branch   (branch),
        .branch_ne(branch_ne),
        .zero     (zero),
        .jump     (jump),
        .jump_reg (jump_reg),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    instr_rom instr_rom_inst (
        .pc   (pc),
        .instr(rom_data)
    );

    instr_decoder instr_decoder_inst (
        .opcode      (instr.r.opcode),
        .funct       (instr.r.funct),
        .alu_op      (alu_op),
        .alu_src_imm (alu_src_imm),
        .imm_zero_ext(imm_zero_ext),
        .reg_dst     (reg_dst),
        .reg_write   (reg_write),
        .wb_sel      (wb_sel),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .branch      (branch),
        .branch_ne   (branch_ne),
        .jump        (jump),
        .jump_reg    (jump_reg)
    );

    // Destination register: rt for I-type, rd for R-type, $ra for jal
    always_comb begin
        case (reg_dst)
            dst_rd:  wa = instr.r.rd;
            dst_ra:  wa = ra_reg;
            default: wa = instr.r.rt;
        endcase
    end

    reg_file reg_file_inst (
        .clk(clk),
        .ra1(instr.r.rs),
        .ra2(instr.r.rt),
        .wa (wa),
        .wd (wd),
        .we (reg_write),
        .rd1(rd1),
        .rd2(rd2)
    );

    // ori zero extends, everything else sign extends
    assign imm_ext = imm_zero_ext ? {16'h0000, instr.i.imm16}
                                  : {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign src_b   = alu_src_imm ? imm_ext : rd2;

    alu alu_inst (
        .a     (rd1),
        .b     (src_b),
        .shamt (instr.r.shamt),
        .op    (alu_op),
        .result(alu_result),
        .zero  (zero)
    );

    data_bus data_bus_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (alu_result),  // Effective address from rs + offset
        .wdata        (rd2),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .rdata        (rdata),
        .gpio_data_out(gpio_data_out)
    );

    // Writeback mux
    always_comb begin
        case (wb_sel)
            wb_mem:  wd = rdata;
            wb_link: wd = pc_plus4;  // Return address for jal
            default: wd = alu_result;
        endcase
    end

endmodule

/* mem/data_bus.sv */
module data_bus import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  logic            mem_read,
    input  logic            mem_write,
    output logic [xlen-1:0] rdata,
    output logic [7:0]      gpio_data_out
);

    logic [xlen-1:0]   ram [ram_words];
    logic [xlen-1:0]   ram_off;         // Translated RAM byte offset
    logic [ram_aw-1:0] ram_idx;
    logic              ram_hit;
    logic              gpio_hit;
    logic [7:0]        gpio_q;

    // Address decode
    assign ram_off  = addr - ram_base;
    assign ram_idx  = ram_off[2 +: ram_aw];
    assign ram_hit  = (addr >= ram_base) && (addr < ram_base + 4 * ram_words);
    assign gpio_hit = (addr == gpio_addr);

    // Word store into RAM
    always_ff @(posedge clk) begin
        if (mem_write && ram_hit) begin
            ram[ram_idx] <= wdata;
        end
    end

    // GPIO output register, only the low byte is kept
    always_ff @(posedge clk) begin
        if (!rst_n)                      gpio_q <= 8'h00;
        else if (mem_write && gpio_hit) gpio_q <= wdata[7:0];
    end

    assign gpio_data_out = gpio_q;

    // Load path
    always_comb begin
        if (!mem_read)     rdata = '0;
        else if (gpio_hit) rdata = {24'h000000, gpio_q};  // Zero extended
        else               rdata = ram[ram_idx];
    end

    // Bus accesses must be word aligned
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) |-> (addr[1:0] == 2'b00))
        else $error("data_bus: misaligned access at %h", addr);

    // and must land in RAM or on the GPIO word
    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_read || mem_write) |-> (ram_hit || gpio_hit))
        else $error("data_bus: unmapped access at %h", addr);

endmodule

/* mem/instr_rom.sv */
module instr_rom import mips_pkg::*; (
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] instr
);

    logic [xlen-1:0] rom [rom_words];
    logic [xlen-1:0] rom_off;               // Physical byte offset into the ROM

    initial $readmemh(rom_file, rom);

    assign rom_off = pc - boot_addr;
    assign instr   = rom[rom_off[2 +: rom_aw]];

    // PC must stay inside the loaded text segment
    // PC holds no fetch address until the first clock edge loads it
    always_comb begin
        if (!$isunknown(pc) && ($time > 0)) begin
            assert (rom_off[xlen-1:2] < rom_words)
                else $error("instr_rom: pc %h outside ROM", pc);
        end
    end

endmodule

/* core/alu.sv */
module alu import mips_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic [4:0]      shamt,
    input  logic [3:0]      op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: begin
                // Signed compare
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            alu_sll: result = b << shamt;   // Shifts operate on rt
            alu_srl: result = b >> shamt;   // Logical, zero fill
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);           // Used by beq and bne

endmodule

/* core/reg_file.sv */
module reg_file import mips_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  logic [4:0]      wa,
    input  logic [xlen-1:0] wd,
    input  logic            we,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);

    logic [xlen-1:0] regs [32];

    // Write at the end of the instruction's cycle, $zero never written
    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

/* core/instr_decoder.sv */
module instr_decoder import mips_pkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output logic [3:0] alu_op,
    output logic       alu_src_imm,
    output logic       imm_zero_ext,
    output logic [1:0] reg_dst,
    output logic       reg_write,
    output logic [1:0] wb_sel,
    output logic       mem_read,
    output logic       mem_write,
    output logic       branch,
    output logic       branch_ne,
    output logic       jump,
    output logic       jump_reg
);

    always_comb begin
        // Safe defaults, acts as a nop
        alu_op       = alu_add;
        alu_src_imm  = 1'b0;
        imm_zero_ext = 1'b0;
        reg_dst      = dst_rt;
        reg_write    = 1'b0;
        wb_sel       = wb_alu;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        branch       = 1'b0;
        branch_ne    = 1'b0;
        jump         = 1'b0;
        jump_reg     = 1'b0;

        case (opcode)
            op_rtype: begin
                reg_dst   = dst_rd;
                reg_write = 1'b1;
                case (funct)
                    fn_add: alu_op = alu_add;
                    fn_sub: alu_op = alu_sub;
                    fn_and: alu_op = alu_and;
                    fn_or:  alu_op = alu_or;
                    fn_slt: alu_op = alu_slt;
                    fn_sll: alu_op = alu_sll;
                    fn_srl: alu_op = alu_srl;
                    fn_jr: begin
                        reg_write = 1'b0;   // No link for jr
                        jump_reg  = 1'b1;
                    end
                    default: reg_write = 1'b0; // Unknown funct, drop it
                endcase
            end
            op_addi: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            op_ori: begin
                alu_op       = alu_or;
                alu_src_imm  = 1'b1;
                imm_zero_ext = 1'b1;
                reg_write    = 1'b1;
            end
            op_lw: begin
                alu_src_imm = 1'b1;           // Address = rs + offset
                reg_write   = 1'b1;
                wb_sel      = wb_mem;
                mem_read    = 1'b1;
            end
            op_sw: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_beq: begin
                alu_op = alu_sub;             // zero flag tells equality
                branch = 1'b1;
            end
            op_bne: begin
                alu_op    = alu_sub;
                branch_ne = 1'b1;
            end
            op_j:   jump = 1'b1;
            op_jal: begin
                jump      = 1'b1;
                reg_dst   = dst_ra;
                reg_write = 1'b1;
                wb_sel    = wb_link;
            end
            default: ;                        // Unknown opcode, sequential nop
        endcase
    end

endmodule

/* core/pc_unit.sv */
module pc_unit import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  instr_t          instr,
    input  logic [xlen-1:0] rs_data,
    input  logic            branch,     // beq
    input  logic            branch_ne,  // bne
    input  logic            zero,
    input  logic            jump,
    input  logic            jump_reg,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] pc_plus4
);

    logic [1:0]      pc_sel;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] jump_target;
    logic [xlen-1:0] pc_next;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr.j.target26, 2'b00}; // Stays in the 256 MB region

    // jr and j win over branches, decoder never raises more than one anyway
    always_comb begin
        if (jump_reg)                                     pc_sel = pc_jreg;
        else if (jump)                                    pc_sel = pc_jump;
        else if ((branch && zero) || (branch_ne && !zero)) pc_sel = pc_branch;
        else                                              pc_sel = pc_seq;
    end

    always_comb begin
        case (pc_sel)
            pc_branch: pc_next = branch_target;
            pc_jump:   pc_next = jump_target;
            pc_jreg:   pc_next = rs_data;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) pc <= boot_addr;
        else        pc <= pc_next;
    end

    // A misaligned jr target would fetch garbage from the ROM
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc_unit: misaligned pc %h", pc);

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

    // Datapath width, also the address width
    localparam int unsigned xlen = 32;

    // Memory map, virtual addresses as seen by the program
    localparam logic [xlen-1:0] boot_addr = 32'h0040_0000; // Reset PC, start of text segment
    localparam int unsigned     rom_words = 64;
    localparam int unsigned     rom_aw    = $clog2(rom_words);
    localparam logic [xlen-1:0] ram_base  = 32'h1001_0000; // Start of data segment
    localparam int unsigned     ram_words = 64;
    localparam int unsigned     ram_aw    = $clog2(ram_words);
    localparam logic [xlen-1:0] gpio_addr = 32'h1001_0100; // First word past the RAM window

    localparam logic [4:0] ra_reg = 5'd31;               // $ra, link register for jal
    localparam rom_file = "dv/prog.hex";                  // Program image, one word per line

    // Opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] fn_sll = 6'h00;
    localparam logic [5:0] fn_srl = 6'h02;
    localparam logic [5:0] fn_jr  = 6'h08;
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    // ALU operations
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_or  = 4'd3;
    localparam logic [3:0] alu_slt = 4'd4;
    localparam logic [3:0] alu_sll = 4'd5;
    localparam logic [3:0] alu_srl = 4'd6;

    // Destination register select
    localparam logic [1:0] dst_rt = 2'd0;
    localparam logic [1:0] dst_rd = 2'd1;
    localparam logic [1:0] dst_ra = 2'd2;

    // Writeback source select
    localparam logic [1:0] wb_alu  = 2'd0;
    localparam logic [1:0] wb_mem  = 2'd1;
    localparam logic [1:0] wb_link = 2'd2;

    // Next-PC source select
    localparam logic [1:0] pc_seq    = 2'd0;
    localparam logic [1:0] pc_branch = 2'd1;
    localparam logic [1:0] pc_jump   = 2'd2;
    localparam logic [1:0] pc_jreg   = 2'd3;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target26;
        } j;
    } instr_t;

endpackage
